/* Makefile */
SIM   := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := stt_rename_tb
FLIST := stt_rename.f
BUILD := obj_dir
LOG   := sim.log

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* hw/epoch_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stt_rename_macros.svh"

module epoch_gen (
    input  wire logic                                        clk,
    input  wire logic                                        rst,
    input  wire stt_rename_pkg::arch_inst_t [`STT_GROUP-1:0] insts,
    input  wire stt_rename_pkg::tag_t                        branch_tail,
    output stt_rename_pkg::tag_t [`STT_GROUP-1:0]            slot_epoch
);

    // epoch of the last slot of the previous group
    stt_rename_pkg::tag_t stored_epoch;

    stt_rename_pkg::tag_t cur_epoch;
    stt_rename_pkg::tag_t br_cnt;

    // ------------------------------------------------------------------------
    // branch numbering inside the group
    // ------------------------------------------------------------------------

    // tag arithmetic wraps modulo 64 on its own
    always_comb begin
        cur_epoch = stored_epoch;
        br_cnt    = '0;
        for (int i = 0; i < `STT_GROUP; i++) begin
            if (insts[i].is_branch) begin
                cur_epoch = branch_tail + br_cnt;
                br_cnt    = br_cnt + 1'b1;
            end
            slot_epoch[i] = cur_epoch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stored_epoch <= '0;
        end else begin
            stored_epoch <= slot_epoch[`STT_GROUP-1];
        end
    end

endmodule

`default_nettype wire

/* hw/rename_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stt_rename_macros.svh"

module rename_map (
    input  wire logic                                        clk,
    input  wire logic                                        rst,
    input  wire stt_rename_pkg::arch_inst_t [`STT_GROUP-1:0] insts,
    input  wire stt_rename_pkg::preg_t [`STT_GROUP-1:0]      free_pregs,
    output stt_rename_pkg::renamed_t [`STT_GROUP-1:0]        renamed,
    output stt_rename_pkg::fwd_sel_t [`STT_GROUP-1:0]        fwd
);

    localparam int NUM_ARCH = 1 << `STT_ARCH_W;

    // register alias table
    stt_rename_pkg::preg_t rat [0:NUM_ARCH-1];

    logic [`STT_GROUP-1:0]                  wr_en;
    logic [`STT_GROUP-1:0][`STT_GROUP-1:0] old_sel;

    // one-hot select of the youngest earlier slot writing register r
    function automatic logic [`STT_GROUP-1:0] match_sel(
        input stt_rename_pkg::areg_t                        r,
        input int                                           slot,
        input logic [`STT_GROUP-1:0]                        wr,
        input stt_rename_pkg::arch_inst_t [`STT_GROUP-1:0] grp
    );
        logic [`STT_GROUP-1:0] sel;
        sel = '0;
        for (int j = 0; j < slot; j++) begin
            if (wr[j] && grp[j].dest == r) begin
                sel = '0;
                sel[j] = 1'b1;
            end
        end
        return sel;
    endfunction

    // forwarded free register if selected, table entry otherwise
    function automatic stt_rename_pkg::preg_t pick(
        input logic [`STT_GROUP-1:0]                   sel,
        input stt_rename_pkg::preg_t                   dflt,
        input stt_rename_pkg::preg_t [`STT_GROUP-1:0] frees
    );
        stt_rename_pkg::preg_t p;
        p = dflt;
        for (int j = 0; j < `STT_GROUP; j++) begin
            if (sel[j]) begin
                p = frees[j];
            end
        end
        return p;
    endfunction

    // register 0 is never renamed
    always_comb begin
        for (int i = 0; i < `STT_GROUP; i++) begin
            wr_en[i] = (insts[i].dest != '0);
        end
    end

    always_comb begin
        for (int i = 0; i < `STT_GROUP; i++) begin
            old_sel[i]      = match_sel(insts[i].dest, i, wr_en, insts);
            fwd[i].src1_sel = match_sel(insts[i].src1, i, wr_en, insts);
            fwd[i].src2_sel = match_sel(insts[i].src2, i, wr_en, insts);
            fwd[i].wr_en    = wr_en[i];

            renamed[i].p_dest     = free_pregs[i];
            renamed[i].old_p_dest = pick(old_sel[i], rat[insts[i].dest], free_pregs);
            renamed[i].p_src1     = pick(fwd[i].src1_sel, rat[insts[i].src1], free_pregs);
            renamed[i].p_src2     = pick(fwd[i].src2_sel, rat[insts[i].src2], free_pregs);
        end
    end

    // later slots overwrite earlier ones on the same register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < NUM_ARCH; a++) begin
                rat[a] <= stt_rename_pkg::preg_t'(a);
            end
        end else begin
            for (int i = 0; i < `STT_GROUP; i++) begin
                if (wr_en[i]) begin
                    rat[insts[i].dest] <= free_pregs[i];
                end
            end
        end
    end

    // an unforwarded source reads what the previous group's last slot wrote
    for (genvar i = 0; i < `STT_GROUP; i++) begin : g_sel_chk
        a_src1_table: assert property (@(posedge clk) disable iff (rst)
            $past(wr_en[`STT_GROUP-1]) && fwd[i].src1_sel == '0 &&
            insts[i].src1 == $past(insts[`STT_GROUP-1].dest)
            |-> renamed[i].p_src1 == $past(free_pregs[`STT_GROUP-1]));
        a_src2_table: assert property (@(posedge clk) disable iff (rst)
            $past(wr_en[`STT_GROUP-1]) && fwd[i].src2_sel == '0 &&
            insts[i].src2 == $past(insts[`STT_GROUP-1].dest)
            |-> renamed[i].p_src2 == $past(free_pregs[`STT_GROUP-1]));
    end

endmodule

`default_nettype wire

/* hw/stt_rename_pkg.sv */
`default_nettype none

`include "stt_rename_macros.svh"

package stt_rename_pkg;

    typedef logic [`STT_ARCH_W-1:0] areg_t;
    typedef logic [`STT_PHYS_W-1:0] preg_t;
    typedef logic [`STT_TAG_W-1:0]  tag_t;

    // one decoded instruction, 14 bits
    typedef struct packed {
        logic  is_branch;
        logic  is_load;
        areg_t dest;
        areg_t src1;
        areg_t src2;
    } arch_inst_t;

    // one renamed instruction, 24 bits
    typedef struct packed {
        preg_t p_dest;
        preg_t old_p_dest;
        preg_t p_src1;
        preg_t p_src2;
    } renamed_t;

    // bit j of a select vector means the source comes from earlier slot j
    typedef struct packed {
        logic [`STT_GROUP-1:0] src1_sel;
        logic [`STT_GROUP-1:0] src2_sel;
        logic                  wr_en;
    } fwd_sel_t;

    // registered input bundle
    typedef struct packed {
        arch_inst_t [`STT_GROUP-1:0] insts;
        preg_t [`STT_GROUP-1:0]      free_pregs;
        tag_t                        branch_tail;
    } group_in_t;

    // registered result of one slot
    typedef struct packed {
        renamed_t ren;
        tag_t     yrot;
    } slot_out_t;

endpackage

`default_nettype wire

/* hw/stt_rename_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stt_rename_macros.svh"

module stt_rename_top (
    input  wire logic                                        clk,
    input  wire logic                                        rst,
    input  wire stt_rename_pkg::arch_inst_t [`STT_GROUP-1:0] insts,
    input  wire stt_rename_pkg::preg_t [`STT_GROUP-1:0]      free_pregs,
    input  wire stt_rename_pkg::tag_t                        branch_tail,
    output stt_rename_pkg::renamed_t [`STT_GROUP-1:0]        renamed,
    output stt_rename_pkg::tag_t [`STT_GROUP-1:0]            yrot
);

    // ------------------------------------------------------------------------
    // input and output registers
    // ------------------------------------------------------------------------

    stt_rename_pkg::group_in_t                  in_d;
    stt_rename_pkg::group_in_t                  in_q;
    stt_rename_pkg::slot_out_t [`STT_GROUP-1:0] out_d;
    stt_rename_pkg::slot_out_t [`STT_GROUP-1:0] out_q;

    stt_rename_pkg::renamed_t [`STT_GROUP-1:0] map_renamed;
    stt_rename_pkg::fwd_sel_t [`STT_GROUP-1:0] map_fwd;
    stt_rename_pkg::tag_t [`STT_GROUP-1:0]     slot_epoch;
    stt_rename_pkg::tag_t [`STT_GROUP-1:0]     slot_yrot;

    assign in_d.insts       = insts;
    assign in_d.free_pregs  = free_pregs;
    assign in_d.branch_tail = branch_tail;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_q  <= '0;
            out_q <= '0;
        end else begin
            in_q  <= in_d;
            out_q <= out_d;
        end
    end

    always_comb begin
        for (int i = 0; i < `STT_GROUP; i++) begin
            out_d[i].ren  = map_renamed[i];
            out_d[i].yrot = slot_yrot[i];
            renamed[i]    = out_q[i].ren;
            yrot[i]       = out_q[i].yrot;
        end
    end

    // ------------------------------------------------------------------------
    // rename and epoch side by side, taint selection joins them
    // ------------------------------------------------------------------------

    rename_map rename_map_inst (
        .clk        (clk),
        .rst        (rst),
        .insts      (in_q.insts),
        .free_pregs (in_q.free_pregs),
        .renamed    (map_renamed),
        .fwd        (map_fwd)
    );

    epoch_gen epoch_gen_inst (
        .clk         (clk),
        .rst         (rst),
        .insts       (in_q.insts),
        .branch_tail (in_q.branch_tail),
        .slot_epoch  (slot_epoch)
    );

    taint_select taint_select_inst (
        .clk        (clk),
        .rst        (rst),
        .insts      (in_q.insts),
        .fwd        (map_fwd),
        .slot_epoch (slot_epoch),
        .yrot       (slot_yrot)
    );

endmodule

`default_nettype wire

/* hw/taint_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stt_rename_macros.svh"

module taint_select (
    input  wire logic                                        clk,
    input  wire logic                                        rst,
    input  wire stt_rename_pkg::arch_inst_t [`STT_GROUP-1:0] insts,
    input  wire stt_rename_pkg::fwd_sel_t [`STT_GROUP-1:0]   fwd,
    input  wire stt_rename_pkg::tag_t [`STT_GROUP-1:0]       slot_epoch,
    output stt_rename_pkg::tag_t [`STT_GROUP-1:0]            yrot
);

    localparam int NUM_ARCH = 1 << `STT_ARCH_W;

    // youngest root of taint per architectural register
    stt_rename_pkg::tag_t taint_tab [0:NUM_ARCH-1];

    stt_rename_pkg::tag_t [`STT_GROUP-1:0] src1_tag;
    stt_rename_pkg::tag_t [`STT_GROUP-1:0] src2_tag;
    stt_rename_pkg::tag_t [`STT_GROUP-1:0] res_tag;

    // ------------------------------------------------------------------------
    // slot walk, oldest first
    // ------------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < `STT_GROUP; i++) begin
            src1_tag[i] = taint_tab[insts[i].src1];
            src2_tag[i] = taint_tab[insts[i].src2];

            // earlier result tags are final by the time slot i is reached
            for (int j = 0; j < i; j++) begin
                if (fwd[i].src1_sel[j]) begin
                    src1_tag[i] = res_tag[j];
                end
                if (fwd[i].src2_sel[j]) begin
                    src2_tag[i] = res_tag[j];
                end
            end

            // larger tag is the younger root
            if (src1_tag[i] > src2_tag[i]) begin
                yrot[i] = src1_tag[i];
            end else begin
                yrot[i] = src2_tag[i];
            end

            // a load becomes a new root under its own epoch
            res_tag[i] = insts[i].is_load ? slot_epoch[i] : yrot[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < NUM_ARCH; a++) begin
                taint_tab[a] <= '0;
            end
        end else begin
            for (int i = 0; i < `STT_GROUP; i++) begin
                if (fwd[i].wr_en) begin
                    taint_tab[insts[i].dest] <= res_tag[i];
                end
            end
        end
    end

    // yrot covers the tag the previous group's last slot stored for a source
    for (genvar i = 0; i < `STT_GROUP; i++) begin : g_yrot_chk
        a_yrot_src1: assert property (@(posedge clk) disable iff (rst)
            $past(fwd[`STT_GROUP-1].wr_en) && fwd[i].src1_sel == '0 &&
            insts[i].src1 == $past(insts[`STT_GROUP-1].dest)
            |-> yrot[i] >= $past(res_tag[`STT_GROUP-1]));
        a_yrot_src2: assert property (@(posedge clk) disable iff (rst)
            $past(fwd[`STT_GROUP-1].wr_en) && fwd[i].src2_sel == '0 &&
            insts[i].src2 == $past(insts[`STT_GROUP-1].dest)
            |-> yrot[i] >= $past(res_tag[`STT_GROUP-1]));
    end

endmodule

`default_nettype wire

/* include/stt_rename_macros.svh */
`ifndef STT_RENAME_MACROS_SVH
`define STT_RENAME_MACROS_SVH

// ------------------------------------------------------------------------
// rename stage sizes
// ------------------------------------------------------------------------

// instructions decoded per cycle
`define STT_GROUP 2

// architectural register index width (16 registers)
`define STT_ARCH_W 4

// physical register index width (64 registers)
`define STT_PHYS_W 6

// yrot and epoch tag width, 0 means untainted
`define STT_TAG_W 6

`endif

/* stt_rename.f */
+incdir+include
hw/stt_rename_pkg.sv
hw/rename_map.sv
hw/epoch_gen.sv
hw/taint_select.sv
hw/stt_rename_top.sv
test/stt_rename_tb.sv

/* test/stt_rename_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stt_rename_macros.svh"

module stt_rename_tb;

    localparam int NUM_GROUPS   = 2000;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_ARCH     = 1 << `STT_ARCH_W;

    logic clk;
    logic rst;

    stt_rename_pkg::arch_inst_t [`STT_GROUP-1:0] insts;
    stt_rename_pkg::preg_t [`STT_GROUP-1:0]      free_pregs;
    stt_rename_pkg::tag_t                        branch_tail;
    stt_rename_pkg::renamed_t [`STT_GROUP-1:0]   renamed;
    stt_rename_pkg::tag_t [`STT_GROUP-1:0]       yrot;

    logic [31:0] lfsr;

    // reference model state
    stt_rename_pkg::preg_t model_rat [0:NUM_ARCH-1];
    stt_rename_pkg::tag_t  model_taint [0:NUM_ARCH-1];
    stt_rename_pkg::tag_t  model_epoch;

    // expected results, oldest group at the front
    stt_rename_pkg::slot_out_t [`STT_GROUP-1:0] exp_q [$];

    stt_rename_top stt_rename_top_inst (
        .clk         (clk),
        .rst         (rst),
        .insts       (insts),
        .free_pregs  (free_pregs),
        .branch_tail (branch_tail),
        .renamed     (renamed),
        .yrot        (yrot)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // random source
    // ------------------------------------------------------------------------

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // ------------------------------------------------------------------------
    // checking
    // ------------------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic compare_outputs();
        stt_rename_pkg::slot_out_t [`STT_GROUP-1:0] exp;
        exp = exp_q.pop_front();
        for (int i = 0; i < `STT_GROUP; i++) begin
            check_value($sformatf("renamed[%0d].p_dest", i), exp[i].ren.p_dest,
                        renamed[i].p_dest);
            check_value($sformatf("renamed[%0d].old_p_dest", i), exp[i].ren.old_p_dest,
                        renamed[i].old_p_dest);
            check_value($sformatf("renamed[%0d].p_src1", i), exp[i].ren.p_src1,
                        renamed[i].p_src1);
            check_value($sformatf("renamed[%0d].p_src2", i), exp[i].ren.p_src2,
                        renamed[i].p_src2);
            check_value($sformatf("yrot[%0d]", i), exp[i].yrot, yrot[i]);
        end
    endtask

    task automatic wait_outputs_clear(input int limit);
        int n;
        n = 0;
        while ((renamed != '0 || yrot != '0) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (renamed != '0 || yrot != '0) begin
            $display("outputs did not clear during reset before the timeout");
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus and reference model
    // ------------------------------------------------------------------------

    // indices from 0..3 keep forwarding and register 0 frequent
    task automatic drive_group();
        logic [31:0] r;
        for (int i = 0; i < `STT_GROUP; i++) begin
            take_bits(1, r);
            insts[i].is_branch = r[0];
            take_bits(1, r);
            insts[i].is_load = r[0];
            take_bits(2, r);
            insts[i].dest = stt_rename_pkg::areg_t'(r[1:0]);
            take_bits(2, r);
            insts[i].src1 = stt_rename_pkg::areg_t'(r[1:0]);
            take_bits(2, r);
            insts[i].src2 = stt_rename_pkg::areg_t'(r[1:0]);
            take_bits(`STT_PHYS_W, r);
            free_pregs[i] = stt_rename_pkg::preg_t'(r);
        end
        take_bits(`STT_TAG_W, r);
        branch_tail = stt_rename_pkg::tag_t'(r);
    endtask

    task automatic predict_group(output stt_rename_pkg::slot_out_t [`STT_GROUP-1:0] exp);
        stt_rename_pkg::tag_t epoch;
        stt_rename_pkg::tag_t tag1;
        stt_rename_pkg::tag_t tag2;
        stt_rename_pkg::tag_t res_tag [`STT_GROUP];
        int                   branches;
        bit                   hit_old;
        bit                   hit1;
        bit                   hit2;
        epoch    = model_epoch;
        branches = 0;
        for (int i = 0; i < `STT_GROUP; i++) begin
            if (insts[i].is_branch) begin
                epoch    = branch_tail + stt_rename_pkg::tag_t'(branches);
                branches = branches + 1;
            end
            exp[i].ren.p_dest     = free_pregs[i];
            exp[i].ren.old_p_dest = model_rat[insts[i].dest];
            exp[i].ren.p_src1     = model_rat[insts[i].src1];
            exp[i].ren.p_src2     = model_rat[insts[i].src2];
            tag1    = model_taint[insts[i].src1];
            tag2    = model_taint[insts[i].src2];
            hit_old = 1'b0;
            hit1    = 1'b0;
            hit2    = 1'b0;
            // search from the nearest older slot, first writer found wins
            for (int j = i - 1; j >= 0; j--) begin
                if (insts[j].dest != '0) begin
                    if (!hit_old && insts[j].dest == insts[i].dest) begin
                        exp[i].ren.old_p_dest = free_pregs[j];
                        hit_old = 1'b1;
                    end
                    if (!hit1 && insts[j].dest == insts[i].src1) begin
                        exp[i].ren.p_src1 = free_pregs[j];
                        tag1 = res_tag[j];
                        hit1 = 1'b1;
                    end
                    if (!hit2 && insts[j].dest == insts[i].src2) begin
                        exp[i].ren.p_src2 = free_pregs[j];
                        tag2 = res_tag[j];
                        hit2 = 1'b1;
                    end
                end
            end
            exp[i].yrot = (tag1 > tag2) ? tag1 : tag2;
            res_tag[i]  = insts[i].is_load ? epoch : exp[i].yrot;
        end
        // commit in slot order so the later slot lands last
        for (int i = 0; i < `STT_GROUP; i++) begin
            if (insts[i].dest != '0) begin
                model_rat[insts[i].dest]   = free_pregs[i];
                model_taint[insts[i].dest] = res_tag[i];
            end
        end
        model_epoch = epoch;
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        stt_rename_pkg::slot_out_t [`STT_GROUP-1:0] exp;
        clk         = 1'b0;
        rst         = 1'b1;
        insts       = '0;
        free_pregs  = '0;
        branch_tail = '0;
        lfsr        = 32'h6858;
        model_epoch = '0;
        for (int a = 0; a < NUM_ARCH; a++) begin
            model_rat[a]   = stt_rename_pkg::preg_t'(a);
            model_taint[a] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        wait_outputs_clear(8);
        @(negedge clk);
        rst = 1'b0;

        // results of a group show up two falling edges after it is driven
        for (int g = 0; g < NUM_GROUPS; g++) begin
            if (exp_q.size() == 2) begin
                compare_outputs();
            end
            drive_group();
            predict_group(exp);
            exp_q.push_back(exp);
            @(negedge clk);
        end

        insts       = '0;
        free_pregs  = '0;
        branch_tail = '0;
        while (exp_q.size() > 0) begin
            compare_outputs();
            @(negedge clk);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
